//--- sim.f
source/fetch_pkg.sv
source/pc_gen.sv
source/inst_rom.sv
source/fetch_stage.sv
source/decode_stage.sv
source/fetch_top.sv
bench/fetch_monitor.sv
bench/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_top
FILELIST  = sim.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST RESULT: FAIL
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/tb_top.sv
module tb_top import fetch_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period          = 40;
    localparam int reset_cycles        = 4;
    localparam int drive_delay         = 2;
    localparam int margin_cycles       = 50;
    // rows this long must deliver words
    localparam int min_progress_cycles = 20;
    localparam int n_rows              = 8;
    // how hold or stall behaves over a row
    localparam int mode_off            = 0;
    localparam int mode_window         = 1;
    localparam int mode_random         = 2;

    logic    clk;
    logic    rst_n;
    logic    flush;
    addr_t   redirect_pc;
    logic    hold;
    logic    stall;
    logic    id_valid;
    addr_t   id_pc;
    inst_t   id_instruction;
    opcode_t id_opcode;
    int      check_count;
    int      monitor_errors;
    int      bench_errors = 0;
    logic [15:0] lfsr = 16'd90;

    ////////////////////////////////////////////////////////////
    // scenario table, one column per field
    ////////////////////////////////////////////////////////////

    string row_name [n_rows] = '{"straight", "stall_window", "hold_window", "random_burst",
                                 "flush_parked", "flush_to_slow", "flush_pending",
                                 "reset_again"};
    int    row_cycles [n_rows] = '{40, 40, 40, 120, 40, 7, 40, 40};
    logic  row_reset [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    int    row_hold [n_rows] = '{mode_off, mode_off, mode_window, mode_random,
                                 mode_off, mode_off, mode_off, mode_off};
    // flush_parked stalls so fetch sits in st_full at the flush
    int    row_stall [n_rows] = '{mode_off, mode_window, mode_off, mode_random,
                                  mode_window, mode_off, mode_off, mode_off};
    // cycle of the one flush pulse, -1 for none
    int    row_flush [n_rows] = '{-1, -1, -1, -1, 18, 0, 0, -1};
    // 0x300c has the slowest latency, still in flight at the next flush
    addr_t row_redirect [n_rows] = '{32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
                                     32'h0000_0000, 32'h0000_2000, 32'h0000_300c,
                                     32'h0000_5000, 32'h0000_0000};

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
    endfunction

    function automatic logic random_bit();
        lfsr = lfsr_step(lfsr);
        return lfsr[0];
    endfunction

    // window covers the second quarter of the row
    function automatic logic input_level(input int mode, input int c, input int cycles);
        case (mode)
            mode_window: return (c >= cycles / 4) && (c < cycles / 2);
            mode_random: return random_bit();
            default:     return 1'b0;
        endcase
    endfunction

    function automatic int total_cycles();
        int sum;
        sum = 0;
        foreach (row_cycles[i]) begin
            sum += row_cycles[i];
        end
        return sum;
    endfunction

    fetch_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .hold           (hold),
        .stall          (stall),
        .id_valid       (id_valid),
        .id_pc          (id_pc),
        .id_instruction (id_instruction),
        .id_opcode      (id_opcode)
    );

    fetch_monitor i_mon (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .stall          (stall),
        .id_valid       (id_valid),
        .id_pc          (id_pc),
        .id_instruction (id_instruction),
        .id_opcode      (id_opcode),
        .error_count    (monitor_errors),
        .check_count    (check_count)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        int start_checks;
        rst_n       = 1'b0;
        flush       = 1'b0;
        hold        = 1'b0;
        stall       = 1'b0;
        redirect_pc = '0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            i_mon.set_test(row_name[r]);
            start_checks = check_count;
            for (int c = 0; c < row_cycles[r]; c++) begin
                @(posedge clk);
                #drive_delay;
                rst_n       = !(row_reset[r] && c < reset_cycles);
                hold        = input_level(row_hold[r], c, row_cycles[r]);
                stall       = input_level(row_stall[r], c, row_cycles[r]);
                flush       = (c == row_flush[r]);
                redirect_pc = row_redirect[r];
            end
            // a stuck pipe shows up as no delivered words
            if (row_cycles[r] >= min_progress_cycles && check_count == start_checks) begin
                bench_errors++;
                $display("no word reached the decode outputs during test %s", row_name[r]);
            end
        end
        @(posedge clk);
        #drive_delay;
        hold  = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        $display("%0d words checked, %0d monitor errors, %0d bench errors",
                 check_count, monitor_errors, bench_errors);
        if (monitor_errors == 0 && bench_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // limit is the whole table plus reset and some slack
    initial begin
        int limit;
        limit = (total_cycles() + reset_cycles + margin_cycles) * clk_period;
        #(limit);
        $display("watchdog expired at %0t ns before the scenario table finished", $time);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- bench/fetch_monitor.sv
module fetch_monitor import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // redirect seen by the DUT
    input  logic    flush,
    input  addr_t   redirect_pc,
    input  logic    stall,
    // decode register outputs
    input  logic    id_valid,
    input  addr_t   id_pc,
    input  inst_t   id_instruction,
    input  opcode_t id_opcode,
    output int      error_count,
    output int      check_count
);

    timeunit 1ns;
    timeprecision 1ps;

    int      errors = 0;
    int      checks = 0;
    string   test_name = "reset";
    // pc of the next word owed by the pipeline
    addr_t   exp_pc = reset_vector;
    inst_t   exp_inst;
    // word held by stall at the last edge
    logic    frozen = 1'b0;
    addr_t   frozen_pc;
    inst_t   frozen_inst;
    opcode_t frozen_opcode;

    assign error_count = errors;
    assign check_count = checks;

    // label used in error lines
    task set_test(input string name);
        test_name = name;
    endtask

    task compare_value(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // sampled on the rising edge, inputs settle 2 ns after it
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            // nothing may leave decode in reset
            compare_value("id_valid in reset", 32'd0, {31'd0, id_valid});
            exp_pc = reset_vector;
            frozen = 1'b0;
        end else begin
            // stalled word must stay put
            if (frozen) begin
                compare_value("id_valid under stall", 32'd1, {31'd0, id_valid});
                compare_value("id_pc under stall", frozen_pc, id_pc);
                compare_value("id_instruction under stall", frozen_inst, id_instruction);
                compare_value("id_opcode under stall", {25'd0, frozen_opcode},
                              {25'd0, id_opcode});
            end
            frozen        = id_valid && stall && !flush;
            frozen_pc     = id_pc;
            frozen_inst   = id_instruction;
            frozen_opcode = id_opcode;
            if (flush) begin
                // decode word killed, stream restarts at the target
                exp_pc = redirect_pc;
            end else if (id_valid && !stall) begin
                // word leaves decode this edge
                exp_inst = exp_pc ^ rom_key;
                compare_value("id_pc", exp_pc, id_pc);
                compare_value("id_instruction", exp_inst, id_instruction);
                compare_value("id_opcode", {25'd0, exp_inst[6:0]}, {25'd0, id_opcode});
                checks++;
                exp_pc = exp_pc + 32'd4;
            end
        end
    end

endmodule

//--- source/fetch_top.sv
module fetch_top import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    flush,
    input  addr_t   redirect_pc,
    input  logic    hold,
    input  logic    stall,
    output logic    id_valid,
    output addr_t   id_pc,
    output inst_t   id_instruction,
    output opcode_t id_opcode
);

    // pre-fetch to fetch
    logic  valid_pre;
    logic  ready_go_pre;
    logic  allow_in_if;
    addr_t next_pc;

    // fetch to memory and decode
    logic  valid_if;
    logic  ready_go_if;
    logic  allow_in_id;
    addr_t pc_if;
    inst_t instruction_if;
    inst_t rom_rdata;
    logic  mem_data_ok;

    ////////////////////////////////////////////////////////////
    // stages
    ////////////////////////////////////////////////////////////

    pc_gen i_pc_gen (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .redirect_pc  (redirect_pc),
        .allow_in_if  (allow_in_if),
        .valid_pre    (valid_pre),
        .ready_go_pre (ready_go_pre),
        .next_pc      (next_pc)
    );

    inst_rom i_inst_rom (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .valid_if    (valid_if),
        .pc_if       (pc_if),
        .rom_rdata   (rom_rdata),
        .mem_data_ok (mem_data_ok)
    );

    fetch_stage i_fetch_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .flush          (flush),
        .mem_data_ok    (mem_data_ok),
        .next_pc        (next_pc),
        .pc_if          (pc_if),
        .rom_rdata      (rom_rdata),
        .instruction_if (instruction_if),
        .allow_in_if    (allow_in_if),
        .valid_pre      (valid_pre),
        .ready_go_pre   (ready_go_pre),
        .allow_in_id    (allow_in_id),
        .valid_if       (valid_if),
        .ready_go_if    (ready_go_if)
    );

    decode_stage i_decode_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .flush          (flush),
        .valid_if       (valid_if),
        .ready_go_if    (ready_go_if),
        .pc_if          (pc_if),
        .instruction_if (instruction_if),
        .allow_in_id    (allow_in_id),
        .id_valid       (id_valid),
        .id_pc          (id_pc),
        .id_instruction (id_instruction),
        .id_opcode      (id_opcode)
    );

endmodule

//--- source/decode_stage.sv
module decode_stage import fetch_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    // freeze from downstream
    input  logic    stall,
    input  logic    flush,
    // from fetch
    input  logic    valid_if,
    input  logic    ready_go_if,
    input  addr_t   pc_if,
    input  inst_t   instruction_if,
    output logic    allow_in_id,
    // decode register outputs
    output logic    id_valid,
    output addr_t   id_pc,
    output inst_t   id_instruction,
    output opcode_t id_opcode
);

    // word moves from fetch
    logic in_go;

    // empty slot always takes a word
    assign allow_in_id = !id_valid || !stall;
    assign in_go       = valid_if && ready_go_if && allow_in_id;

    ////////////////////////////////////////////////////////////
    // pipeline register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (allow_in_id) begin
            id_valid <= in_go;
        end
    end

    always_ff @(posedge clk) begin
        if (in_go) begin
            id_pc          <= pc_if;
            id_instruction <= instruction_if;
        end
    end

    // opcode field
    assign id_opcode = id_instruction[6:0];

    // stalled word must not move
    a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        id_valid && stall && !flush |=> id_valid && $stable(id_pc) &&
        $stable(id_instruction) && $stable(id_opcode));

endmodule

//--- source/fetch_stage.sv
module fetch_stage import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // stop words leaving fetch
    input  logic  hold,
    input  logic  flush,
    // memory side
    input  logic  mem_data_ok,
    input  addr_t next_pc,
    output addr_t pc_if,
    input  inst_t rom_rdata,
    output inst_t instruction_if,
    // to pre-fetch
    output logic  allow_in_if,
    input  logic  valid_pre,
    input  logic  ready_go_pre,
    // to decode
    input  logic  allow_in_id,
    output logic  valid_if,
    output logic  ready_go_if
);

    fetch_state_t state;
    fetch_state_t next_state;

    // parked word for a busy decode
    inst_t park;
    logic  park_valid;

    logic  word_here;
    logic  out_go;
    logic  take_pre;

    // live answer for the held address
    assign word_here = valid_if && mem_data_ok;

    // word available unless hold or still draining
    assign ready_go_if = valid_if && !hold &&
                         ((state == st_full) ||
                          (mem_data_ok && (state == st_empty || state == st_pipe)));

    assign out_go = ready_go_if && allow_in_id;

    // in leap the slot frees when the stale word returns
    assign allow_in_if = (state == st_leap) ? mem_data_ok : (!valid_if || out_go);

    assign take_pre = valid_pre && ready_go_pre && allow_in_if && !flush;

    // parked word first
    assign instruction_if = park_valid ? park : rom_rdata;

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_leap: begin
                // drop the stale word
                if (mem_data_ok) begin
                    next_state = st_empty;
                end
            end
            st_empty, st_pipe: begin
                if (flush) begin
                    // still waiting on memory so drain it
                    if (valid_if && !mem_data_ok) begin
                        next_state = st_leap;
                    end else begin
                        next_state = st_empty;
                    end
                end else if (word_here && out_go) begin
                    next_state = st_pipe;
                end else if (word_here) begin
                    next_state = st_full;
                end else begin
                    next_state = st_empty;
                end
            end
            st_full: begin
                if (flush || out_go) begin
                    next_state = st_empty;
                end
            end
            default: begin
                next_state = st_empty;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_empty;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////////////////////////////////////////////
    // address slot
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_if <= 1'b0;
        end else if (take_pre) begin
            valid_if <= 1'b1;
        end else if (allow_in_if || (flush && next_state != st_leap)) begin
            // word gone or flushed
            valid_if <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take_pre) begin
            pc_if <= next_pc;
        end
    end

    // parking register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            park_valid <= 1'b0;
        end else if (flush || out_go) begin
            // word left or was killed
            park_valid <= 1'b0;
        end else if (word_here && state != st_leap) begin
            park_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (word_here && !park_valid) begin
            park <= rom_rdata;
        end
    end

    a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(state));

    // parked word belongs to a live address
    a_full_parked: assert property (@(posedge clk) disable iff (!rst_n)
        (state == st_full) |-> park_valid && valid_if);

endmodule

//--- source/inst_rom.sv
module inst_rom import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // kills the request in flight
    input  logic  flush,
    // request from fetch
    input  logic  valid_if,
    input  addr_t pc_if,
    // answer
    output inst_t rom_rdata,
    output logic  mem_data_ok
);

    // wide enough for the slowest answer
    typedef logic [$clog2(max_latency + 1) - 1:0] lat_t;

    lat_t  count;
    addr_t req_pc;
    // current address already answered
    logic  done;
    logic  new_req;

    // idle and the address is not the one just served
    assign new_req = valid_if && (count == '0) && !(done && pc_if == req_pc);

    ////////////////////////////////////////////////////////////
    // latency counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
            done  <= 1'b0;
        end else if (flush) begin
            // abort and forget the last address
            count <= '0;
            done  <= 1'b0;
        end else if (new_req) begin
            // 1 to 4 cycles from address bits 3:2
            count <= lat_t'(pc_if[3:2]) + lat_t'(1);
            done  <= 1'b0;
        end else if (count != '0) begin
            count <= count - lat_t'(1);
            if (count == lat_t'(1)) begin
                done <= 1'b1;
            end
        end
    end

    // latched request address
    always_ff @(posedge clk) begin
        if (new_req) begin
            req_pc <= pc_if;
        end
    end

    // last count cycle carries the word
    assign mem_data_ok = (count == lat_t'(1));
    // data only valid with the pulse
    assign rom_rdata   = mem_data_ok ? (req_pc ^ rom_key) : '0;

    // one answer per request, and only for the address fetch still holds
    a_single_answer: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> valid_if && (pc_if == req_pc));

endmodule

//--- source/pc_gen.sv
module pc_gen import fetch_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    // redirect from a later stage
    input  logic  flush,
    input  addr_t redirect_pc,
    // fetch stage can take an address
    input  logic  allow_in_if,
    output logic  valid_pre,
    output logic  ready_go_pre,
    // address offered to fetch
    output addr_t next_pc
);

    // address moves into fetch this cycle
    logic to_if;

    // address is known as soon as it is held
    assign ready_go_pre = 1'b1;

    // flush blocks the handoff of the old path
    assign to_if = valid_pre && ready_go_pre && allow_in_if && !flush;

    ////////////////////////////////////////////////////////////
    // program counter
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_pre <= 1'b0;
            next_pc   <= reset_vector;
        end else begin
            // valid from the first cycle out of reset
            valid_pre <= 1'b1;
            if (flush) begin
                // redirect wins over fetch back-pressure
                next_pc <= redirect_pc;
            end else if (to_if) begin
                next_pc <= next_pc + 32'd4;
            end
        end
    end

    // redirect targets must be word aligned as well
    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        next_pc[1:0] == 2'b00);

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////

    // byte address of an instruction
    typedef logic [31:0] addr_t;
    // raw instruction word
    typedef logic [31:0] inst_t;
    // low seven bits of the word
    typedef logic [6:0]  opcode_t;

    ////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////

    // first pc fetched after reset
    localparam addr_t reset_vector = 32'h0000_1000;
    // rom word is address xor this key
    localparam inst_t rom_key      = 32'h5ac3_0f93;
    // slowest rom answer in cycles
    localparam int    max_latency  = 4;

    // fetch stage control, one bit per state
    typedef enum logic [3:0] {
        st_leap  = 4'b0001,
        st_empty = 4'b0010,
        st_pipe  = 4'b0100,
        st_full  = 4'b1000
    } fetch_state_t;

endpackage
